// ==== vlog.f ====
+incdir+include
design/note_pkg.sv
design/wb_pkg.sv
design/melody_sequencer.sv
design/note_fifo.sv
design/tone_generator.sv
design/song_player.sv
testbench/song_player_props.sv
testbench/song_player_tb.sv

// ==== Makefile ====
SIM := obj_dir/song_player_tb

SOURCES := vlog.f include/song_config.svh \
	design/note_pkg.sv design/wb_pkg.sv design/melody_sequencer.sv \
	design/note_fifo.sv design/tone_generator.sv design/song_player.sv \
	testbench/song_player_props.sv testbench/song_player_tb.sv

.PHONY: all run clean

all: run

$(SIM): $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module song_player_tb -Mdir obj_dir -o song_player_tb

run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; echo "$$out"; \
		echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== testbench/song_player_tb.sv ====
// Testbench for the music box that drives reset and play, follows the song order and sums every check
`timescale 1ns/1ps
`default_nettype none

`include "song_config.svh"

module song_player_tb;

  import note_pkg::*;

  localparam int TEST_COUNT = 6;

  logic        clk_4hz;
  logic        clk_6mhz;
  logic        rst_n;
  logic        play;
  logic        speaker;
  logic [3:0]  digit_high;
  logic [3:0]  digit_med;
  logic [3:0]  digit_low;

  // Scoreboard state
  int          errors;
  int          tests_failed;
  int          test_start;
  int          change_count;
  int          wrap_count;
  logic [11:0] last_shown;
  logic [5:0]  exp_idx;
  logic        started;

  song_player song_player_i (
    .clk_4hz    (clk_4hz),
    .clk_6mhz   (clk_6mhz),
    .rst_n      (rst_n),
    .play       (play),
    .speaker    (speaker),
    .digit_high (digit_high),
    .digit_med  (digit_med),
    .digit_low  (digit_low)
  );

  bind song_player song_player_props props_i (
    .clk_4hz    (clk_4hz),
    .clk_6mhz   (clk_6mhz),
    .rst_n      (rst_n),
    .play       (play),
    .speaker    (speaker),
    .digit_high (digit_high),
    .digit_med  (digit_med),
    .digit_low  (digit_low)
  );

  ////////////////////
  // Clocks
  ////////////////////

  initial
  begin
    clk_4hz = 1'b0;
    forever #5 clk_4hz = ~clk_4hz;
  end

  // Tone clock half a ns off the beat edges
  initial
  begin
    clk_6mhz = 1'b0;
    #0.5;
    forever #1 clk_6mhz = ~clk_6mhz;
  end

  ////////////////////
  // Song model
  ////////////////////

  // One entry on with a wrap after the last
  function automatic logic [5:0] step_index(input logic [5:0] idx);
    if (idx == 6'(`SONG_LEN - 1))
      return 6'd0;
    return idx + 6'd1;
  endfunction

  // Next entry that changes the display since repeats do not show
  function automatic logic [5:0] next_change(input logic [5:0] idx);
    logic [5:0] n;
    n = step_index(idx);
    for (int i = 0; i < `SONG_LEN; i++)
    begin
      if (song_note(n) != song_note(idx))
        break;
      n = step_index(n);
    end
    return n;
  endfunction

  // Own mismatches plus assertion failures in the bound checker
  function automatic int total_errors();
    return errors + song_player_i.props_i.fail_cnt;
  endfunction

  // Order check on every change of the digit triple
  always @(negedge clk_4hz)
  begin : order_monitor
    logic [11:0] shown;
    logic [5:0]  idx;
    shown = {digit_high, digit_med, digit_low};
    if (!rst_n)
    begin
      last_shown = '0;
      started    = 1'b0;
    end
    else if (shown != last_shown)
    begin
      idx = started ? next_change(exp_idx) : 6'd0;
      // Back to the start of the song
      if (started && idx < exp_idx)
        wrap_count++;
      assert (shown == song_note(idx))
      else
      begin
        $display("FAILED at time %0t: digits %h, expected entry %0d code %h",
                 $time, shown, idx, song_note(idx));
        errors++;
      end
      exp_idx    = idx;
      started    = 1'b1;
      last_shown = shown;
      change_count++;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic drive_play(input logic value);
    @(negedge clk_4hz);
    play = value;
  endtask

  // A beat is two beat clock cycles
  task automatic hold_paused(input int beats);
    drive_play(1'b0);
    repeat (2 * beats) @(negedge clk_4hz);
  endtask

  task automatic wait_changes(input int count, input int limit, input string what);
    int goal;
    int cycles;
    goal   = change_count + count;
    cycles = 0;
    while (change_count < goal && cycles < limit)
    begin
      @(posedge clk_4hz);
      cycles++;
    end
    if (change_count < goal)
    begin
      $display("Timeout: %s did not show %0d new notes in %0d cycles", what, count, limit);
      errors++;
    end
  endtask

  task automatic wait_wraps(input int count, input int limit);
    int goal;
    int cycles;
    goal   = wrap_count + count;
    cycles = 0;
    while (wrap_count < goal && cycles < limit)
    begin
      @(posedge clk_4hz);
      cycles++;
    end
    if (wrap_count < goal)
    begin
      $display("Timeout: song did not wrap %0d times in %0d cycles", count, limit);
      errors++;
    end
  endtask

  // Speaker edges counted in tone clock cycles
  task automatic wait_toggles(input int count, input int limit);
    int   seen;
    int   cycles;
    logic prev;
    seen   = 0;
    cycles = 0;
    prev   = speaker;
    while (seen < count && cycles < limit)
    begin
      @(negedge clk_6mhz);
      if (speaker != prev)
        seen++;
      prev = speaker;
      cycles++;
    end
    if (seen < count)
    begin
      $display("Timeout: speaker toggled %0d of %0d times in %0d cycles", seen, count, limit);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    int found;
    found = total_errors() - test_start;
    if (found == 0)
      $display("%s: passed", name);
    else
    begin
      $display("%s: failed with %0d errors", name, found);
      tests_failed++;
    end
    test_start = total_errors();
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial
  begin : main_flow
    int hold_beats;
    rst_n        = 1'b0;
    play         = 1'b0;
    errors       = 0;
    tests_failed = 0;
    test_start   = 0;
    change_count = 0;
    wrap_count   = 0;
    void'($urandom(32'h19ed));

    // Reset for 10 beat cycles and checked a little past release
    repeat (10) @(negedge clk_4hz);
    rst_n = 1'b1;
    repeat (2) @(negedge clk_4hz);
    end_test("reset");

    // Rest shown while nothing plays yet
    hold_paused(8);
    assert (change_count == 0)
    else
    begin
      $display("FAILED at time %0t: digits left the rest code while paused", $time);
      errors++;
    end
    end_test("rest");

    drive_play(1'b1);
    wait_changes(30, 400, "song order");
    end_test("song order");

    // Two more passes through the end of the table
    wait_wraps(2, 600);
    end_test("wrap");

    for (int r = 0; r < 3; r++)
    begin
      hold_beats = $urandom_range(40, 10);
      hold_paused(hold_beats);
      drive_play(1'b1);
      wait_changes(3, 200, "resume");
    end
    end_test("pause and resume");

    // Long pause so several half periods complete
    hold_paused(4);
    wait_toggles(5, 100000);
    drive_play(1'b1);
    wait_changes(2, 200, "resume after pitch");
    end_test("pitch");

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
             TEST_COUNT, TEST_COUNT - tests_failed, tests_failed, total_errors());
    if (tests_failed == 0 && total_errors() == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/song_player_props.sv ====
// Concurrent checks on the music box outputs, bound to the top level from the testbench
`timescale 1ns/1ps
`default_nettype none

module song_player_props (
  input logic       clk_4hz,
  input logic       clk_6mhz,
  input logic       rst_n,
  input logic       play,
  input logic       speaker,
  input logic [3:0] digit_high,
  input logic [3:0] digit_med,
  input logic [3:0] digit_low
);

  import note_pkg::*;

  logic [11:0] shown;
  logic [11:0] shown_q;
  logic        spk_q;
  logic [15:0] gap;
  logic [1:0]  edges_seen;
  int          fail_cnt = 0;

  assign shown = {digit_high, digit_med, digit_low};

  ////////////////////
  // Edge tracking
  ////////////////////

  // Tone cycles since the last speaker edge, edges since the digits last moved
  always_ff @(posedge clk_6mhz)
  begin
    if (!rst_n)
    begin
      spk_q      <= 1'b0;
      shown_q    <= '0;
      gap        <= '0;
      edges_seen <= '0;
    end
    else
    begin
      spk_q   <= speaker;
      shown_q <= shown;
      if (speaker != spk_q)
        gap <= 16'd1;
      else if (gap != 16'hffff)
        gap <= gap + 16'd1;
      // First interval after a change may mix old and new tone
      if (shown != shown_q)
        edges_seen <= '0;
      else if (speaker != spk_q && edges_seen != 2'd3)
        edges_seen <= edges_seen + 2'd1;
    end
  end

  ////////////////////
  // Properties
  ////////////////////

  // Quiet outputs in reset and the beat after
  reset_quiet: assert property (@(posedge clk_4hz)
    !rst_n |=> (!speaker && shown == 12'h000))
  else
  begin
    $error("speaker or digits not cleared by reset");
    fail_cnt++;
  end

  // Rest code keeps the speaker low
  rest_silent: assert property (@(posedge clk_6mhz) disable iff (!rst_n)
    (shown == 12'h000) |-> !speaker)
  else
  begin
    $error("speaker active while the rest code is shown");
    fail_cnt++;
  end

  // A read started before the pause can still land, after that the digits hold
  pause_holds: assert property (@(posedge clk_4hz) disable iff (!rst_n)
    (!play && !$past(play) && !$past(play, 2) && !$past(play, 3)) |-> $stable(shown))
  else
  begin
    $error("digits changed while playback was paused");
    fail_cnt++;
  end

  // Settled tone toggles every half period
  pitch_period: assert property (@(posedge clk_6mhz) disable iff (!rst_n)
    ((speaker != spk_q) && (shown == shown_q) && (edges_seen >= 2'd2))
    |-> (gap == 16'(half_period(note_code_u'(shown)))))
  else
  begin
    $error("speaker half period does not match the shown note");
    fail_cnt++;
  end

endmodule

`default_nettype wire

// ==== design/song_player.sv ====
// Music box top level joining the song sequencer, the note buffer and the tone generator
`timescale 1ns/1ps
`default_nettype none

module song_player (
  input  logic       clk_4hz,
  input  logic       clk_6mhz,
  input  logic       rst_n,
  input  logic       play,
  output logic       speaker,
  output logic [3:0] digit_high,
  output logic [3:0] digit_med,
  output logic [3:0] digit_low
);

  ////////////////////
  // Write bus
  ////////////////////

  logic        wr_cyc;
  logic        wr_stb;
  logic        wr_we;
  logic [11:0] wr_dat;
  logic        wr_ack;

  ////////////////////
  // Read bus
  ////////////////////

  logic        rd_cyc;
  logic        rd_stb;
  logic [15:0] rd_dat;
  logic        rd_ack;

  // Song source
  melody_sequencer melody_sequencer_i (
    .clk_4hz (clk_4hz),
    .rst_n   (rst_n),
    .wr_cyc  (wr_cyc),
    .wr_stb  (wr_stb),
    .wr_we   (wr_we),
    .wr_dat  (wr_dat),
    .wr_ack  (wr_ack)
  );

  // Elastic store between the two masters
  note_fifo note_fifo_i (
    .clk_4hz (clk_4hz),
    .rst_n   (rst_n),
    .wr_cyc  (wr_cyc),
    .wr_stb  (wr_stb),
    .wr_we   (wr_we),
    .wr_dat  (wr_dat),
    .wr_ack  (wr_ack),
    .rd_cyc  (rd_cyc),
    .rd_stb  (rd_stb),
    .rd_dat  (rd_dat),
    .rd_ack  (rd_ack)
  );

  // Playback and sound
  tone_generator tone_generator_i (
    .clk_4hz    (clk_4hz),
    .clk_6mhz   (clk_6mhz),
    .rst_n      (rst_n),
    .play       (play),
    .rd_cyc     (rd_cyc),
    .rd_stb     (rd_stb),
    .rd_dat     (rd_dat),
    .rd_ack     (rd_ack),
    .speaker    (speaker),
    .digit_high (digit_high),
    .digit_med  (digit_med),
    .digit_low  (digit_low)
  );

endmodule

`default_nettype wire

// ==== design/tone_generator.sv ====
// Fetches one note per beat over Wishbone, shows it on the digits and drives the speaker pitch
`timescale 1ns/1ps
`default_nettype none

`include "song_config.svh"

module tone_generator (
  input  logic        clk_4hz,
  input  logic        clk_6mhz,
  input  logic        rst_n,
  input  logic        play,
  // Wishbone classic read master
  output logic        rd_cyc,
  output logic        rd_stb,
  input  logic [15:0] rd_dat,
  input  logic        rd_ack,
  // Board outputs
  output logic        speaker,
  output logic [3:0]  digit_high,
  output logic [3:0]  digit_med,
  output logic [3:0]  digit_low
);

  import note_pkg::*;
  import wb_pkg::*;

  // Divider value that means carry
  localparam logic [`TONE_DIV_BITS-1:0] DIV_TOP = '1;

  note_code_u                cur_note;
  logic                      note_tgl;
  logic [1:0]                rst_sync;
  logic                      tone_rst_n;
  logic [2:0]                tgl_sync;
  logic                      tgl_edge;
  note_code_u                tone_code;
  logic [`TONE_DIV_BITS-1:0] tone_origin;
  logic [`TONE_DIV_BITS-1:0] divider;
  logic                      carry;

  ////////////////////
  // Beat domain
  ////////////////////

  always_ff @(posedge clk_4hz)
  begin
    if (!rst_n)
    begin
      rd_stb   <= 1'b0;
      cur_note <= '0;
      note_tgl <= 1'b0;
    end
    else
    begin
      // Hold strobe until ack, then go again only while playing
      if (!rd_stb || rd_ack)
        rd_stb <= play;
      // Empty answers keep the old note
      if (rd_stb && rd_ack && read_valid(rd_dat))
      begin
        cur_note.raw <= read_code(rd_dat);
        note_tgl     <= ~note_tgl;
      end
    end
  end

  assign rd_cyc = rd_stb;

  // Digits from the field view
  assign digit_high = cur_note.digit[2];
  assign digit_med  = cur_note.digit[1];
  assign digit_low  = cur_note.digit[0];

  ////////////////////
  // Tone domain
  ////////////////////

  // Reset asserts at once, releases two tone cycles later
  always_ff @(posedge clk_6mhz)
    rst_sync <= {rst_sync[0], rst_n};

  assign tone_rst_n = rst_n && rst_sync[1];

  // Toggle synchronizer, top bit is the last seen level
  always_ff @(posedge clk_6mhz)
  begin
    if (!tone_rst_n)
      tgl_sync <= '0;
    else
      tgl_sync <= {tgl_sync[1:0], note_tgl};
  end

  // New note waiting in the beat domain
  assign tgl_edge    = tgl_sync[2] ^ tgl_sync[1];
  assign tone_origin = note_origin(tone_code);
  assign carry       = (divider == DIV_TOP);

  always_ff @(posedge clk_6mhz)
  begin
    if (!tone_rst_n)
    begin
      tone_code <= '0;
      divider   <= DIV_TOP;
      speaker   <= 1'b0;
    end
    else
    begin
      // Beat side code is stable once the toggle is seen here
      if (tgl_edge)
      begin
        tone_code <= cur_note;
        divider   <= note_origin(cur_note);
      end
      else if (carry)
        divider <= tone_origin;
      else
        divider <= divider + 1'b1;
      // Silent on a rest
      if (tone_code.raw == '0)
        speaker <= 1'b0;
      else if (carry)
        speaker <= ~speaker;
    end
  end

endmodule

`default_nettype wire

// ==== design/note_fifo.sv ====
// Circular note buffer with a Wishbone write slave for the sequencer and a read slave for playback
`timescale 1ns/1ps
`default_nettype none

`include "song_config.svh"

module note_fifo #(
  parameter int DEPTH = `NOTE_FIFO_DEPTH
) (
  input  logic        clk_4hz,
  input  logic        rst_n,
  // Write slave
  input  logic        wr_cyc,
  input  logic        wr_stb,
  input  logic        wr_we,
  input  logic [11:0] wr_dat,
  output logic        wr_ack,
  // Read slave
  input  logic        rd_cyc,
  input  logic        rd_stb,
  output logic [15:0] rd_dat,
  output logic        rd_ack
);

  import wb_pkg::*;

  localparam int              PTR_W    = $clog2(DEPTH);
  localparam logic [PTR_W:0]  FULL_CNT = (PTR_W + 1)'(DEPTH);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  logic [11:0]      mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             full;
  logic             empty;
  logic             wr_req;
  logic             wr_fire;
  logic             rd_req;
  logic             rd_take;

  // Pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_PTR)
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full  = (count == FULL_CNT);
  assign empty = (count == '0);

  // New requests only, the cycle of an ack is not a second request
  assign wr_req  = wr_cyc && wr_stb && wr_we && !wr_ack;
  assign wr_fire = wr_req && !full;
  assign rd_req  = rd_cyc && rd_stb && !rd_ack;
  assign rd_take = rd_req && !empty;

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_4hz)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      wr_ack <= 1'b0;
      rd_ack <= 1'b0;
    end
    else
    begin
      // Full withholds the write ack
      wr_ack <= wr_fire;
      // Reads always ack, valid or not
      rd_ack <= rd_req;
      if (wr_fire)
        wr_ptr <= ptr_next(wr_ptr);
      if (rd_take)
        rd_ptr <= ptr_next(rd_ptr);
      // Push and pop together leave the count alone
      case ({wr_fire, rd_take})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_4hz)
  begin
    if (wr_fire)
      mem[wr_ptr] <= wr_dat;
    // Empty buffer answers with valid clear
    if (rd_req)
      rd_dat <= pack_read(!empty, mem[rd_ptr]);
  end

endmodule

`default_nettype wire

// ==== design/melody_sequencer.sv ====
// Beat-domain song stepper that pushes each note code into the buffer as a Wishbone write master
`timescale 1ns/1ps
`default_nettype none

`include "song_config.svh"

module melody_sequencer (
  input  logic        clk_4hz,
  input  logic        rst_n,
  // Wishbone classic write master
  output logic        wr_cyc,
  output logic        wr_stb,
  output logic        wr_we,
  output logic [11:0] wr_dat,
  input  logic        wr_ack
);

  import note_pkg::*;

  // Master states
  localparam logic ST_IDLE  = 1'b0;
  localparam logic ST_WRITE = 1'b1;

  // Index of the final song entry
  localparam logic [5:0] LAST_IDX = 6'(`SONG_LEN - 1);

  logic       state;
  logic [5:0] song_idx;
  logic       wr_done;

  ////////////////////
  // Bus master
  ////////////////////

  // Buffer took the current entry
  assign wr_done = (state == ST_WRITE) && wr_ack;

  // One quiet cycle out of reset, then writes back to back
  // Strobe stays up across an ack so the next entry follows at once
  always_ff @(posedge clk_4hz)
  begin
    if (!rst_n)
      state <= ST_IDLE;
    else if (state == ST_IDLE)
      state <= ST_WRITE;
  end

  assign wr_cyc = (state == ST_WRITE);
  assign wr_stb = (state == ST_WRITE);
  assign wr_we  = (state == ST_WRITE);

  ////////////////////
  // Song index
  ////////////////////

  // Advance only on ack, back-pressure holds the index
  always_ff @(posedge clk_4hz)
  begin
    if (!rst_n)
      song_idx <= '0;
    else if (wr_done)
    begin
      // Wrap back to the first note
      if (song_idx == LAST_IDX)
        song_idx <= '0;
      else
        song_idx <= song_idx + 6'd1;
    end
  end

  // Data follows the index, stable until ack
  assign wr_dat = song_note(song_idx);

endmodule

`default_nettype wire

// ==== design/wb_pkg.sv ====
// Layout of the 16-bit Wishbone read word from the note buffer, with pack and unpack helpers
`default_nettype none

package wb_pkg;

  // Bit 15 valid flag, bits 14..12 spare, bits 11..0 note code

  // Build a read word, spare bits zero
  function automatic logic [15:0] pack_read(input logic valid, input logic [11:0] code);
    return {valid, 3'b000, code};
  endfunction

  // Word carries a real entry
  function automatic logic read_valid(input logic [15:0] word);
    return word[15];
  endfunction

  // Note code field
  function automatic logic [11:0] read_code(input logic [15:0] word);
    return word[11:0];
  endfunction

endpackage

`default_nettype wire

// ==== design/note_pkg.sv ====
// Music data shared by the RTL and the testbench: note code view, song table and pitch lookup
`default_nettype none

`include "song_config.svh"

package note_pkg;

  // One 12-bit note code, seen as a raw key or as three display digits
  // digit[2] is the high octave, digit[1] the middle, digit[0] the low
  typedef union packed {
    logic [11:0]     raw;
    logic [2:0][3:0] digit;
  } note_code_u;

  ////////////////////
  // Song table
  ////////////////////

  // Melody in playing order, rest for anything past the end
  function automatic logic [11:0] song_note(input logic [5:0] idx);
    case (idx)
      6'd0, 6'd1, 6'd2, 6'd3:  return 12'h003;
      6'd4, 6'd5, 6'd6:        return 12'h005;
      6'd7:                    return 12'h006;
      6'd8, 6'd9, 6'd10:       return 12'h010;
      6'd11:                   return 12'h020;
      6'd12:                   return 12'h006;
      6'd13:                   return 12'h010;
      6'd14, 6'd15:            return 12'h005;
      6'd16, 6'd17, 6'd18:     return 12'h050;
      6'd19:                   return 12'h100;
      6'd20:                   return 12'h060;
      6'd21:                   return 12'h050;
      6'd22:                   return 12'h030;
      6'd23:                   return 12'h050;
      // Long held middle note
      6'd24, 6'd25, 6'd26, 6'd27, 6'd28, 6'd29,
      6'd30, 6'd31, 6'd32, 6'd33, 6'd34:
                               return 12'h020;
      6'd35:                   return 12'h030;
      6'd36, 6'd37:            return 12'h007;
      6'd38, 6'd39:            return 12'h006;
      6'd40, 6'd41, 6'd42:     return 12'h005;
      6'd43:                   return 12'h006;
      6'd44, 6'd45:            return 12'h010;
      6'd46, 6'd47:            return 12'h020;
      default:                 return 12'h000;
    endcase
  endfunction

  ////////////////////
  // Pitch
  ////////////////////

  // Divider start value per note, higher start gives a higher pitch
  function automatic logic [`TONE_DIV_BITS-1:0] note_origin(input note_code_u code);
    case (code.raw)
      12'h003: return 14'd7281;
      12'h005: return 14'd8730;
      12'h006: return 14'd9565;
      12'h007: return 14'd10310;
      12'h010: return 14'd10647;
      12'h020: return 14'd11272;
      12'h030: return 14'd11831;
      12'h050: return 14'd12556;
      12'h060: return 14'd12974;
      12'h100: return 14'd13516;
      // Rest and unknown codes never leave the carry value
      default: return 14'd16383;
    endcase
  endfunction

  // Tone clock cycles between two speaker edges
  function automatic logic [`TONE_DIV_BITS:0] half_period(input note_code_u code);
    return (`TONE_DIV_BITS + 1)'(2 ** `TONE_DIV_BITS)
           - (`TONE_DIV_BITS + 1)'(note_origin(code));
  endfunction

endpackage

`default_nettype wire

// ==== include/song_config.svh ====
// Song length, buffer depth and pitch divider width, included by the packages and the RTL

`ifndef SONG_CONFIG_SVH
`define SONG_CONFIG_SVH

////////////////////
// Song
////////////////////

// Entries in the fixed melody table
`define SONG_LEN 48

////////////////////
// Note buffer
////////////////////

// Default number of buffered note codes
`define NOTE_FIFO_DEPTH 4

////////////////////
// Tone divider
////////////////////

// Width of the pitch divider
// All ones is the carry value, so a load of all ones means no tone
`define TONE_DIV_BITS 14

`endif
